// File: rtl/dma_pkg.sv
// Shared widths, types and constants of the descriptor DMA engine
// Descriptor layout, register offsets and queue depths
`default_nettype none

package dma_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 16;
  localparam int unsigned WordBytes = DataWidth / 8; // Byte step between words

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [LenWidth-1:0]  len_t;

  // Transfer request handed from frontend to backend
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } xfer_req_t;

  typedef logic mst_id_t;
  localparam mst_id_t MstFrontend = 1'b0;
  localparam mst_id_t MstBackend  = 1'b1;

  localparam int unsigned XferQueueDepth = 4;
  localparam int unsigned MemOutstanding = 4;
  localparam int unsigned DescWords      = 4;

  typedef logic [$clog2(XferQueueDepth+1)-1:0] credit_t;
  typedef logic [$clog2(DescWords)-1:0]        word_idx_t;
  typedef logic [15:0]                         cnt_t;

  localparam addr_t RegHeadOffset   = 32'h0000_0000;
  localparam addr_t RegStatusOffset = 32'h0000_0004;

  // Word positions inside a descriptor
  localparam int unsigned DescSrcIdx  = 0;
  localparam int unsigned DescDstIdx  = 1;
  localparam int unsigned DescLenIdx  = 2;
  localparam int unsigned DescNextIdx = 3;

endpackage : dma_pkg

`default_nettype wire

// File: rtl/credit_fifo.sv
// Small circular FIFO with a type parameter for its payload
// Head entry is visible on data_o while not empty
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
  parameter type         item_t = logic,
  parameter int unsigned Depth  = 4
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  push_i,
  input  item_t data_i,
  input  logic  pop_i,
  output item_t data_o,
  output logic  empty_o,
  output logic  full_o
);

  item_t                    mem_q [Depth];
  logic [$clog2(Depth)-1:0] wr_ptr_q;
  logic [$clog2(Depth)-1:0] rd_ptr_q;
  logic [$clog2(Depth):0]   count_q;
  logic                     do_push;
  logic                     do_pop;

  assign full_o  = (count_q == Depth);
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : credit_fifo

`default_nettype wire

// File: rtl/desc_frontend.sv
// Descriptor frontend: register port, descriptor fetch FSM,
// transfer credits, completion counting and chain interrupt
`timescale 1ns/10ps
`default_nettype none

module desc_frontend (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               reg_valid_i,
  input  logic               reg_we_i,
  input  dma_pkg::addr_t     reg_addr_i,
  input  dma_pkg::data_t     reg_wdata_i,
  output dma_pkg::data_t     reg_rdata_o,
  output logic               reg_ready_o,
  output logic               irq_o,
  output logic               xfer_valid_o,
  output dma_pkg::xfer_req_t xfer_req_o,
  input  logic               xfer_credit_i,
  input  logic               xfer_done_i,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output dma_pkg::addr_t     mem_addr_o,
  output dma_pkg::data_t     mem_wdata_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  dma_pkg::data_t     mem_rdata_i
);

  typedef enum logic [1:0] {FeIdle, FeFetch, FeIssue, FeDrain} fe_state_e;

  fe_state_e          state_q;
  dma_pkg::addr_t     desc_addr_q;    // Descriptor currently fetched
  dma_pkg::addr_t     next_q;
  dma_pkg::xfer_req_t desc_q;
  dma_pkg::word_idx_t word_cnt_q;
  logic               rd_pending_q;   // Read granted, data still out
  dma_pkg::credit_t   credit_q;
  dma_pkg::cnt_t      done_cnt_q;
  dma_pkg::cnt_t      chain_issued_q;
  dma_pkg::cnt_t      chain_done_q;
  logic               busy_q;
  logic               irq_q;
  logic               head_we;
  logic               issue;
  logic               last_done;

  assign reg_ready_o = reg_valid_i;
  assign head_we     = reg_valid_i & reg_we_i & (reg_addr_i == dma_pkg::RegHeadOffset) & ~busy_q;

  always_comb begin
    reg_rdata_o = '0;
    if (reg_addr_i == dma_pkg::RegStatusOffset) begin
      reg_rdata_o[31]   = busy_q;
      reg_rdata_o[15:0] = done_cnt_q;
    end else if (reg_addr_i == dma_pkg::RegHeadOffset) begin
      reg_rdata_o = desc_addr_q;
    end
  end

  assign issue     = (state_q == FeIssue) & (credit_q != '0);
  assign last_done = (state_q == FeDrain) & xfer_done_i & (chain_done_q + 1'b1 == chain_issued_q);

  // Descriptor words are read one at a time, never overlapped
  assign mem_req_o   = (state_q == FeFetch) & ~rd_pending_q;
  assign mem_we_o    = 1'b0;
  assign mem_wdata_o = '0;
  assign mem_addr_o  = desc_addr_q + dma_pkg::addr_t'(word_cnt_q) * dma_pkg::WordBytes;

  assign xfer_valid_o = issue;
  assign xfer_req_o   = desc_q;
  assign irq_o        = irq_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= FeIdle;
      desc_addr_q  <= '0;
      word_cnt_q   <= '0;
      rd_pending_q <= 1'b0;
      busy_q       <= 1'b0;
      irq_q        <= 1'b0;
    end else begin
      irq_q <= last_done; // One cycle after the final completion
      unique case (state_q)
        FeIdle: begin
          if (head_we) begin
            state_q     <= FeFetch;
            desc_addr_q <= reg_wdata_i;
            word_cnt_q  <= '0;
            busy_q      <= 1'b1;
          end
        end
        FeFetch: begin
          if (mem_req_o && mem_gnt_i) begin
            rd_pending_q <= 1'b1;
          end
          if (mem_rvalid_i) begin
            rd_pending_q <= 1'b0;
            word_cnt_q   <= word_cnt_q + 1'b1;
            if (word_cnt_q == dma_pkg::DescWords - 1) begin
              state_q    <= FeIssue;
              word_cnt_q <= '0;
            end
          end
        end
        FeIssue: begin
          if (issue) begin
            if (next_q == '0) begin
              state_q <= FeDrain;
            end else begin
              state_q     <= FeFetch;
              desc_addr_q <= next_q;
            end
          end
        end
        FeDrain: begin
          if (last_done) begin
            state_q <= FeIdle;
            busy_q  <= 1'b0;
          end
        end
        default: state_q <= FeIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == FeFetch && mem_rvalid_i) begin
      case (word_cnt_q)
        dma_pkg::DescSrcIdx:  desc_q.src <= mem_rdata_i;
        dma_pkg::DescDstIdx:  desc_q.dst <= mem_rdata_i;
        dma_pkg::DescLenIdx:  desc_q.len <= mem_rdata_i[dma_pkg::LenWidth-1:0];
        dma_pkg::DescNextIdx: next_q     <= mem_rdata_i;
        default:              next_q     <= next_q;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q       <= dma_pkg::credit_t'(dma_pkg::XferQueueDepth);
      done_cnt_q     <= '0;
      chain_issued_q <= '0;
      chain_done_q   <= '0;
    end else begin
      case ({issue, xfer_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
      if (xfer_done_i) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
      if (head_we) begin
        chain_issued_q <= '0;
        chain_done_q   <= '0;
      end else begin
        if (issue) begin
          chain_issued_q <= chain_issued_q + 1'b1;
        end
        if (xfer_done_i) begin
          chain_done_q <= chain_done_q + 1'b1;
        end
      end
    end
  end

endmodule : desc_frontend

`default_nettype wire

// File: rtl/xfer_backend.sv
// Transfer backend: request queue, credit return and
// word-by-word copy from source to destination
`timescale 1ns/10ps
`default_nettype none

module xfer_backend (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               xfer_valid_i,
  input  dma_pkg::xfer_req_t xfer_req_i,
  output logic               xfer_credit_o,
  output logic               xfer_done_o,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output dma_pkg::addr_t     mem_addr_o,
  output dma_pkg::data_t     mem_wdata_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  dma_pkg::data_t     mem_rdata_i
);

  typedef enum logic [2:0] {BeIdle, BeRdReq, BeRdWait, BeWrReq, BeWrWait} be_state_e;

  be_state_e          state_q;
  dma_pkg::xfer_req_t head_req;
  logic               q_empty;
  logic               pop;
  dma_pkg::addr_t     src_q;
  dma_pkg::addr_t     dst_q;
  dma_pkg::len_t      rem_q;   // Words left in this transfer
  dma_pkg::data_t     data_q;
  logic               done_q;
  logic               wr_ack;

  // Credits keep the queue from ever filling up
  credit_fifo #(
    .item_t ( dma_pkg::xfer_req_t     ),
    .Depth  ( dma_pkg::XferQueueDepth )
  ) i_req_queue (
    .clk_i,
    .arst_n_i,
    .push_i  ( xfer_valid_i ),
    .data_i  ( xfer_req_i   ),
    .pop_i   ( pop          ),
    .data_o  ( head_req     ),
    .empty_o ( q_empty      ),
    .full_o  (              )
  );

  assign pop    = (state_q == BeIdle) & ~q_empty;
  assign wr_ack = (state_q == BeWrWait) & mem_rvalid_i;

  assign xfer_credit_o = pop;
  assign xfer_done_o   = done_q;

  assign mem_req_o   = (state_q == BeRdReq) | (state_q == BeWrReq);
  assign mem_we_o    = (state_q == BeWrReq);
  assign mem_addr_o  = (state_q == BeWrReq) ? dst_q : src_q;
  assign mem_wdata_o = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BeIdle;
      rem_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      // Zero-length requests complete right after the pop
      done_q <= (pop && head_req.len == '0) || (wr_ack && rem_q == 1);
      unique case (state_q)
        BeIdle: begin
          if (pop && head_req.len != '0) begin
            state_q <= BeRdReq;
            rem_q   <= head_req.len;
          end
        end
        BeRdReq:  if (mem_gnt_i) state_q <= BeRdWait;
        BeRdWait: if (mem_rvalid_i) state_q <= BeWrReq;
        BeWrReq:  if (mem_gnt_i) state_q <= BeWrWait;
        BeWrWait: begin
          if (mem_rvalid_i) begin
            rem_q   <= rem_q - 1'b1;
            state_q <= (rem_q == 1) ? BeIdle : BeRdReq;
          end
        end
        default: state_q <= BeIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      src_q <= head_req.src;
      dst_q <= head_req.dst;
    end else if (wr_ack) begin
      src_q <= src_q + dma_pkg::WordBytes;
      dst_q <= dst_q + dma_pkg::WordBytes;
    end
    if (state_q == BeRdWait && mem_rvalid_i) begin
      data_q <= mem_rdata_i; // Held for the write phase
    end
  end

endmodule : xfer_backend

`default_nettype wire

// File: rtl/mem_arbiter.sv
// Round-robin arbiter of two memory masters onto one port
// Responses return in grant order through an id queue
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           fe_req_i,
  input  logic           fe_we_i,
  input  dma_pkg::addr_t fe_addr_i,
  input  dma_pkg::data_t fe_wdata_i,
  output logic           fe_gnt_o,
  output logic           fe_rvalid_o,
  output dma_pkg::data_t fe_rdata_o,
  input  logic           be_req_i,
  input  logic           be_we_i,
  input  dma_pkg::addr_t be_addr_i,
  input  dma_pkg::data_t be_wdata_i,
  output logic           be_gnt_o,
  output logic           be_rvalid_o,
  output dma_pkg::data_t be_rdata_o,
  output logic           mem_req_o,
  output logic           mem_we_o,
  output dma_pkg::addr_t mem_addr_o,
  output dma_pkg::data_t mem_wdata_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  dma_pkg::data_t mem_rdata_i
);

  dma_pkg::mst_id_t prio_q;   // Winner when both masters request
  dma_pkg::mst_id_t sel_id;
  dma_pkg::mst_id_t head_id;  // Owner of the next response
  logic             order_empty;
  logic             order_full;
  logic             grant;

  always_comb begin
    if (fe_req_i && be_req_i) begin
      sel_id = prio_q;
    end else if (be_req_i) begin
      sel_id = dma_pkg::MstBackend;
    end else begin
      sel_id = dma_pkg::MstFrontend;
    end
  end

  assign mem_req_o   = (fe_req_i | be_req_i) & ~order_full;
  assign mem_we_o    = (sel_id == dma_pkg::MstBackend) ? be_we_i    : fe_we_i;
  assign mem_addr_o  = (sel_id == dma_pkg::MstBackend) ? be_addr_i  : fe_addr_i;
  assign mem_wdata_o = (sel_id == dma_pkg::MstBackend) ? be_wdata_i : fe_wdata_i;

  assign grant    = mem_req_o & mem_gnt_i;
  assign fe_gnt_o = grant & (sel_id == dma_pkg::MstFrontend);
  assign be_gnt_o = grant & (sel_id == dma_pkg::MstBackend);

  credit_fifo #(
    .item_t ( dma_pkg::mst_id_t       ),
    .Depth  ( dma_pkg::MemOutstanding )
  ) i_order_queue (
    .clk_i,
    .arst_n_i,
    .push_i  ( grant        ),
    .data_i  ( sel_id       ),
    .pop_i   ( mem_rvalid_i ),
    .data_o  ( head_id      ),
    .empty_o ( order_empty  ),
    .full_o  ( order_full   )
  );

  assign fe_rvalid_o = mem_rvalid_i & ~order_empty & (head_id == dma_pkg::MstFrontend);
  assign be_rvalid_o = mem_rvalid_i & ~order_empty & (head_id == dma_pkg::MstBackend);
  assign fe_rdata_o  = mem_rdata_i;
  assign be_rdata_o  = mem_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q <= dma_pkg::MstFrontend;
    end else if (grant) begin
      prio_q <= ~sel_id; // Other master goes first next time
    end
  end

endmodule : mem_arbiter

`default_nettype wire

// File: rtl/dma_desc_top.sv
// Top level of the descriptor DMA engine
// Frontend and backend share one memory port through the arbiter
`timescale 1ns/10ps
`default_nettype none

module dma_desc_top (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           reg_valid_i,
  input  logic           reg_we_i,
  input  dma_pkg::addr_t reg_addr_i,
  input  dma_pkg::data_t reg_wdata_i,
  output dma_pkg::data_t reg_rdata_o,
  output logic           reg_ready_o,
  output logic           irq_o,
  output logic           mem_req_o,
  output logic           mem_we_o,
  output dma_pkg::addr_t mem_addr_o,
  output dma_pkg::data_t mem_wdata_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  dma_pkg::data_t mem_rdata_i
);

  logic               xfer_valid;
  dma_pkg::xfer_req_t xfer_req;
  logic               xfer_credit;
  logic               xfer_done;

  logic               fe_req;
  logic               fe_we;
  logic               fe_gnt;
  logic               fe_rvalid;
  dma_pkg::addr_t     fe_addr;
  dma_pkg::data_t     fe_wdata;
  dma_pkg::data_t     fe_rdata;
  logic               be_req;
  logic               be_we;
  logic               be_gnt;
  logic               be_rvalid;
  dma_pkg::addr_t     be_addr;
  dma_pkg::data_t     be_wdata;
  dma_pkg::data_t     be_rdata;

  desc_frontend i_frontend (
    .clk_i,
    .arst_n_i,
    .reg_valid_i,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_ready_o,
    .irq_o,
    .xfer_valid_o  ( xfer_valid  ),
    .xfer_req_o    ( xfer_req    ),
    .xfer_credit_i ( xfer_credit ),
    .xfer_done_i   ( xfer_done   ),
    .mem_req_o     ( fe_req      ),
    .mem_we_o      ( fe_we       ),
    .mem_addr_o    ( fe_addr     ),
    .mem_wdata_o   ( fe_wdata    ),
    .mem_gnt_i     ( fe_gnt      ),
    .mem_rvalid_i  ( fe_rvalid   ),
    .mem_rdata_i   ( fe_rdata    )
  );

  xfer_backend i_backend (
    .clk_i,
    .arst_n_i,
    .xfer_valid_i  ( xfer_valid  ),
    .xfer_req_i    ( xfer_req    ),
    .xfer_credit_o ( xfer_credit ),
    .xfer_done_o   ( xfer_done   ),
    .mem_req_o     ( be_req      ),
    .mem_we_o      ( be_we       ),
    .mem_addr_o    ( be_addr     ),
    .mem_wdata_o   ( be_wdata    ),
    .mem_gnt_i     ( be_gnt      ),
    .mem_rvalid_i  ( be_rvalid   ),
    .mem_rdata_i   ( be_rdata    )
  );

  mem_arbiter i_arbiter (
    .clk_i,
    .arst_n_i,
    .fe_req_i    ( fe_req    ),
    .fe_we_i     ( fe_we     ),
    .fe_addr_i   ( fe_addr   ),
    .fe_wdata_i  ( fe_wdata  ),
    .fe_gnt_o    ( fe_gnt    ),
    .fe_rvalid_o ( fe_rvalid ),
    .fe_rdata_o  ( fe_rdata  ),
    .be_req_i    ( be_req    ),
    .be_we_i     ( be_we     ),
    .be_addr_i   ( be_addr   ),
    .be_wdata_i  ( be_wdata  ),
    .be_gnt_o    ( be_gnt    ),
    .be_rvalid_o ( be_rvalid ),
    .be_rdata_o  ( be_rdata  ),
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i
  );

endmodule : dma_desc_top

`default_nettype wire

// File: test/tb_mem_model.sv
// Word-addressed memory model for the DMA memory port
// Random grant stalls from an LFSR, response one cycle after the grant
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
  parameter int unsigned MemWords = 4096
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        stall_en_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  localparam int unsigned IdxWidth = $clog2(MemWords);

  logic [31:0]         mem_q [MemWords]; // Also written by the testbench backdoor
  logic [31:0]         lfsr_q;
  logic [IdxWidth-1:0] idx;

  // Fibonacci LFSR with taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  assign idx   = addr_i[IdxWidth+1:2];
  assign gnt_o = req_i & (~stall_en_i | lfsr_q[31]);

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q   <= 32'h059a_3580;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      if (req_i && stall_en_i) begin
        lfsr_q <= lfsr_step(lfsr_q); // One bit used this cycle
      end
      rvalid_o <= gnt_o;
      if (gnt_o) begin
        rdata_o <= we_i ? '0 : mem_q[idx];
        if (we_i) begin
          mem_q[idx] <= wdata_i;
        end
      end
    end
  end

endmodule : tb_mem_model

`default_nettype wire

// File: test/tb_dma_desc.sv
// Testbench for the descriptor DMA engine
// Test table, clock and reset, memory checks and reporting
`timescale 1ns/10ps
`default_nettype none

module tb_dma_desc;

  localparam int unsigned NumCases   = 5;
  localparam int unsigned MemWords   = 4096;
  localparam int unsigned Timeout    = 20000;
  localparam logic [31:0] DescBase   = 32'h0000_0100;
  localparam logic [31:0] RegionStep = 32'h0000_0100; // Spacing of per-descriptor regions

  typedef struct packed {
    logic [1:0]  ndesc;
    logic [15:0] len0;
    logic [15:0] len1;
    logic [15:0] len2;
    logic [31:0] src;
    logic [31:0] dst;
    logic        stall;
  } case_t;

  logic        clk;
  logic        arst_n;
  logic        reg_valid;
  logic        reg_we;
  logic [31:0] reg_addr;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        reg_ready;
  logic        irq;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_gnt;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;
  logic        stall_en;
  case_t       cases [NumCases];
  int unsigned test_errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned irq_count;
  int unsigned exp_done;   // Completed transfers since reset
  logic        timed_out;

  always #2 clk = ~clk;

  always @(negedge clk) begin
    if (irq) begin
      irq_count++;
    end
  end

  dma_desc_top u_dut (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .reg_valid_i  ( reg_valid  ),
    .reg_we_i     ( reg_we     ),
    .reg_addr_i   ( reg_addr   ),
    .reg_wdata_i  ( reg_wdata  ),
    .reg_rdata_o  ( reg_rdata  ),
    .reg_ready_o  ( reg_ready  ),
    .irq_o        ( irq        ),
    .mem_req_o    ( mem_req    ),
    .mem_we_o     ( mem_we     ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wdata_o  ( mem_wdata  ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  )
  );

  tb_mem_model #(.MemWords(MemWords)) u_mem (
    .clk_i      ( clk        ),
    .arst_n_i   ( arst_n     ),
    .stall_en_i ( stall_en   ),
    .req_i      ( mem_req    ),
    .we_i       ( mem_we     ),
    .addr_i     ( mem_addr   ),
    .wdata_i    ( mem_wdata  ),
    .gnt_o      ( mem_gnt    ),
    .rvalid_o   ( mem_rvalid ),
    .rdata_o    ( mem_rdata  )
  );

  // Source data and background fill depend on the whole address
  function automatic logic [31:0] src_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] bg_word(input logic [31:0] addr);
    return ~addr ^ 32'h6b1d_2e07;
  endfunction

  function automatic logic [31:0] desc_len(input case_t c, input int k);
    case (k)
      0:       return 32'(c.len0);
      1:       return 32'(c.len1);
      default: return 32'(c.len2);
    endcase
  endfunction

  task automatic mem_write(input logic [31:0] addr, input logic [31:0] data);
    u_mem.mem_q[addr[13:2]] = data;
  endtask

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, act, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, test_errors);
    end
  endtask

  task automatic preload(input case_t c);
    logic [31:0] addr;
    for (int i = 0; i < MemWords; i++) begin
      u_mem.mem_q[i] = bg_word(32'(i) << 2);
    end
    for (int k = 0; k < c.ndesc; k++) begin
      for (int w = 0; w < desc_len(c, k); w++) begin
        addr = c.src + k * RegionStep + 4 * w;
        mem_write(addr, src_word(addr));
      end
      addr = DescBase + 16 * k;
      mem_write(addr + 4 * dma_pkg::DescSrcIdx, c.src + k * RegionStep);
      mem_write(addr + 4 * dma_pkg::DescDstIdx, c.dst + k * RegionStep);
      mem_write(addr + 4 * dma_pkg::DescLenIdx, desc_len(c, k));
      mem_write(addr + 4 * dma_pkg::DescNextIdx, (k == c.ndesc - 1) ? 32'h0 : addr + 16);
    end
  endtask

  task automatic run_case(input int idx);
    case_t       c;
    int unsigned cycles;
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] len;
    c           = cases[idx];
    test_errors = 0;
    exp_done    = exp_done + c.ndesc; // Zero-length transfers count too
    preload(c);
    @(negedge clk);
    irq_count = 0;
    @(posedge clk);
    stall_en  <= c.stall;
    reg_we    <= 1'b1;
    reg_addr  <= dma_pkg::RegHeadOffset;
    reg_wdata <= DescBase;
    @(posedge clk);
    reg_we   <= 1'b0;
    reg_addr <= dma_pkg::RegStatusOffset;
    @(negedge clk);
    cycles = 0;
    while (!irq && cycles < Timeout) begin
      check_value("status busy", 32'(reg_rdata[31]), 32'd1); // Set until the interrupt
      @(negedge clk);
      cycles++;
    end
    if (!irq) begin
      $display("Case %0d timed out waiting for the interrupt after %0d cycles", idx, cycles);
      timed_out = 1'b1;
      test_errors++;
    end else begin
      repeat (16) @(negedge clk); // Window for a stray second interrupt
      check_value("irq_o pulses", irq_count, 32'd1);
      check_value("status busy", 32'(reg_rdata[31]), 32'd0);
      check_value("status count", 32'(reg_rdata[15:0]), exp_done & 32'hffff);
      for (int k = 0; k < c.ndesc; k++) begin
        src = c.src + k * RegionStep;
        dst = c.dst + k * RegionStep;
        len = desc_len(c, k);
        for (int w = 0; w < len; w++) begin
          check_value($sformatf("mem[0x%08h]", dst + 4 * w), u_mem.mem_q[(dst >> 2) + w],
                      src_word(src + 4 * w));
        end
        check_value($sformatf("mem[0x%08h]", dst + 4 * len), u_mem.mem_q[(dst >> 2) + len],
                    bg_word(dst + 4 * len));
      end
    end
    finish_test($sformatf("case %0d", idx));
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    reg_valid    = 1'b0;
    reg_we       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    stall_en     = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    irq_count    = 0;
    exp_done     = 0;
    timed_out    = 1'b0;
    // ndesc, lengths, source base, destination base, stalls
    cases[0] = '{2'd1, 16'd8,  16'd0, 16'd0,  32'h0000_1000, 32'h0000_2000, 1'b0};
    cases[1] = '{2'd3, 16'd5,  16'd3, 16'd7,  32'h0000_1400, 32'h0000_2400, 1'b0};
    cases[2] = '{2'd3, 16'd4,  16'd0, 16'd6,  32'h0000_1800, 32'h0000_2800, 1'b0};
    cases[3] = '{2'd3, 16'd9,  16'd1, 16'd12, 32'h0000_1c00, 32'h0000_2c00, 1'b1};
    cases[4] = '{2'd2, 16'd16, 16'd0, 16'd2,  32'h0000_3000, 32'h0000_3800, 1'b1};
    repeat (3) @(posedge clk);
    @(negedge clk);
    test_errors = 0;
    check_value("reg_ready_o", 32'(reg_ready), 32'd0);
    @(posedge clk);
    arst_n    <= 1'b1;
    reg_valid <= 1'b1;
    reg_addr  <= dma_pkg::RegStatusOffset;
    @(negedge clk);
    check_value("irq_o", 32'(irq), 32'd0);
    check_value("mem_req_o", 32'(mem_req), 32'd0);
    check_value("reg_rdata_o", reg_rdata, 32'd0);
    check_value("reg_ready_o", 32'(reg_ready), 32'd1);
    finish_test("reset");
    for (int i = 0; i < NumCases && !timed_out; i++) begin
      run_case(i);
    end
    $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
    if (tests_failed == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_dma_desc

`default_nettype wire

// File: tb.f
rtl/dma_pkg.sv
rtl/credit_fifo.sv
rtl/desc_frontend.sv
rtl/xfer_backend.sv
rtl/mem_arbiter.sv
rtl/dma_desc_top.sv
test/tb_mem_model.sv
test/tb_dma_desc.sv

// File: Bender.yml
package:
  name: dma_desc

sources:
  - files:
      - rtl/dma_pkg.sv
      - rtl/credit_fifo.sv
      - rtl/desc_frontend.sv
      - rtl/xfer_backend.sv
      - rtl/mem_arbiter.sv
      - rtl/dma_desc_top.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_dma_desc.sv
